// File: bench/tb_cfo_correct.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cfo_correct;
    import sample_pkg::*;
    import cfo_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int ANGLE_TOL = 4;
    localparam int EST_LATENCY = 23;
    localparam int RANDOM_PAIRS = 20;
    localparam int STREAM_LEN = 8;

    logic clk_i;
    logic reset_ni;
    logic corr_valid_i;
    cplx_t corr_c0_i;
    cplx_t corr_c1_i;
    logic smp_valid_i;
    cplx_t smp_i;
    angle_t cfo_angle_o;
    dds_inc_t cfo_inc_o;
    logic cfo_valid_o;
    logic out_valid_o;
    cplx_t out_o;

    int cycle_cnt = 0;
    // NCO model state, phase and the increment it steps by
    longint model_phase = 0;
    longint model_inc = 0;
    cplx_t smp_in_q[$];
    cplx_t exp_out_q[$];

    cfo_correct_top cfo_correct_top_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .corr_valid_i (corr_valid_i),
        .corr_c0_i    (corr_c0_i),
        .corr_c1_i    (corr_c1_i),
        .smp_valid_i  (smp_valid_i),
        .smp_i        (smp_i),
        .cfo_angle_o  (cfo_angle_o),
        .cfo_inc_o    (cfo_inc_o),
        .cfo_valid_o  (cfo_valid_o),
        .out_valid_o  (out_valid_o),
        .out_o        (out_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout: tests still running after %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    task automatic check_value(input string name, input longint actual,
                               input longint expected, input longint tol);
        longint diff;
        diff = actual - expected;
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > tol) begin
            $display("[ERROR] %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            report_failure($sformatf("%s is off by more than %0d", name, tol));
        end
    endtask

    function automatic longint round_to_int(input real x);
        return (x >= 0.0) ? longint'($rtoi(x + 0.5)) : longint'($rtoi(x - 0.5));
    endfunction

    // +pi and -pi name the same direction
    task automatic check_angle(input string name, input longint actual, input longint expected);
        longint near;
        near = expected;
        if (actual - near > 2**(CFO_W-1)) begin
            near = near + 2**CFO_W;
        end else if (near - actual > 2**(CFO_W-1)) begin
            near = near - 2**CFO_W;
        end
        check_value(name, actual, near, ANGLE_TOL);
    endtask

    // atan2 of c0 * conj(c1) after the product shift, in angle codes
    task automatic ref_angle(input cplx_t c0, input cplx_t c1, output longint angle);
        longint full_re;
        longint full_im;
        iq_t p_re;
        iq_t p_im;
        real a;
        full_re = longint'(c0.re) * c1.re + longint'(c0.im) * c1.im;
        full_im = longint'(c0.im) * c1.re - longint'(c0.re) * c1.im;
        p_re = iq_t'(full_re >>> PROD_SHIFT);
        p_im = iq_t'(full_im >>> PROD_SHIFT);
        a = $atan2(real'(p_im), real'(p_re)) * real'(PI_HALF) / (PI_REAL / 2.0);
        angle = round_to_int(a);
    endtask

    function automatic longint sine_code(input longint addr);
        real amp;
        amp = real'(2**(IQ_W-1) - 1);
        return round_to_int(amp * $sin(2.0 * PI_REAL * real'(addr) / real'(2**SIN_LUT_AW)));
    endfunction

    // one sample through the NCO rule, then the phase steps on
    task automatic model_derotate(input cplx_t s, output cplx_t e);
        longint addr;
        longint sin_v;
        longint cos_v;
        addr = model_phase >> (DDS_W - SIN_LUT_AW);
        sin_v = sine_code(addr);
        cos_v = sine_code((addr + 2**(SIN_LUT_AW-2)) % 2**SIN_LUT_AW);
        e.re = iq_t'((longint'(s.re) * cos_v + longint'(s.im) * sin_v) >>> (IQ_W-1));
        e.im = iq_t'((longint'(s.im) * cos_v - longint'(s.re) * sin_v) >>> (IQ_W-1));
        model_phase = (model_phase + model_inc + 2**DDS_W) % 2**DDS_W;
    endtask

    function automatic iq_t random_component();
        iq_t mag;
        mag = iq_t'($urandom_range(3000, 11000));
        return ($urandom_range(0, 1) == 1) ? -mag : mag;
    endfunction

    task automatic run_estimate(input cplx_t c0, input cplx_t c1, output longint angle);
        int wait_cycles;
        corr_c0_i = c0;
        corr_c1_i = c1;
        corr_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        corr_valid_i = 1'b0;
        wait_cycles = 0;
        while (cfo_valid_o !== 1'b1) begin
            if (wait_cycles > 2 * EST_LATENCY) begin
                report_failure("no estimate came out after a correlation pair");
            end
            @(posedge clk_i);
            #2;
            wait_cycles++;
        end
        check_value("cfo_valid_o latency", wait_cycles, EST_LATENCY, 0);
        angle = longint'(cfo_angle_o);
        check_value("cfo_inc_o", longint'(cfo_inc_o), angle >>> (CFO_W - DDS_W), 0);
        @(posedge clk_i);
        #2;
        check_value("cfo_valid_o", longint'(cfo_valid_o), 0, 0);
    endtask

    // output j is due two cycles after input j, with no gaps
    task automatic stream_samples(input longint tol);
        int n;
        n = smp_in_q.size();
        for (int k = 0; k < n + 3; k++) begin
            if (k >= 2 && k - 2 < n) begin
                check_value("out_valid_o", longint'(out_valid_o), 1, 0);
                check_value("out_o.re", longint'(out_o.re), longint'(exp_out_q[k-2].re), tol);
                check_value("out_o.im", longint'(out_o.im), longint'(exp_out_q[k-2].im), tol);
            end else begin
                check_value("out_valid_o", longint'(out_valid_o), 0, 0);
            end
            smp_valid_i = (k < n);
            smp_i = (k < n) ? smp_in_q[k] : '0;
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic test_reset_state();
        check_value("cfo_valid_o", longint'(cfo_valid_o), 0, 0);
        check_value("out_valid_o", longint'(out_valid_o), 0, 0);
        check_value("cfo_angle_o", longint'(cfo_angle_o), 0, 0);
        check_value("cfo_inc_o", longint'(cfo_inc_o), 0, 0);
    endtask

    task automatic test_passthrough();
        cplx_t s;
        cplx_t e;
        smp_in_q.delete();
        exp_out_q.delete();
        for (int k = 0; k < STREAM_LEN; k++) begin
            s.re = iq_t'($urandom);
            s.im = iq_t'($urandom);
            e.re = iq_t'((longint'(s.re) * (2**(IQ_W-1) - 1)) >>> (IQ_W-1));
            e.im = iq_t'((longint'(s.im) * (2**(IQ_W-1) - 1)) >>> (IQ_W-1));
            smp_in_q.push_back(s);
            exp_out_q.push_back(e);
        end
        stream_samples(0);
    endtask

    task automatic test_axis_cases();
        cplx_t base;
        cplx_t c0;
        longint angle;
        base.re = 16'sd8000;
        base.im = '0;
        run_estimate(base, base, angle);
        check_angle("cfo_angle_o at 0 deg", angle, 0);
        c0.re = '0;
        c0.im = 16'sd8000;
        run_estimate(c0, base, angle);
        check_angle("cfo_angle_o at +90 deg", angle, PI_HALF);
        c0.re = -16'sd8000;
        c0.im = '0;
        run_estimate(c0, base, angle);
        check_angle("cfo_angle_o at 180 deg", angle, 2 * longint'(PI_HALF));
        c0.re = '0;
        c0.im = -16'sd8000;
        run_estimate(c0, base, angle);
        check_angle("cfo_angle_o at -90 deg", angle, -longint'(PI_HALF));
    endtask

    // c0 is c1 turned into one octant in turn, so every quadrant and
    // both sides of the swap boundary come up
    task automatic test_random_pairs();
        cplx_t c0;
        cplx_t c1;
        real phi;
        longint expected;
        longint angle;
        for (int k = 0; k < RANDOM_PAIRS; k++) begin
            c1.re = random_component();
            c1.im = random_component();
            phi = (real'(k % 8) + 0.05 + 0.9 * real'($urandom_range(0, 999)) / 1000.0)
                  * PI_REAL / 4.0;
            c0.re = iq_t'(round_to_int(real'(c1.re) * $cos(phi) - real'(c1.im) * $sin(phi)));
            c0.im = iq_t'(round_to_int(real'(c1.re) * $sin(phi) + real'(c1.im) * $cos(phi)));
            ref_angle(c0, c1, expected);
            run_estimate(c0, c1, angle);
            check_angle($sformatf("cfo_angle_o pair %0d", k), angle, expected);
        end
    endtask

    // a +90 deg estimate turns the NCO about a quarter turn per sample
    task automatic test_derotation();
        cplx_t c0;
        cplx_t c1;
        cplx_t s;
        cplx_t e;
        longint angle;
        c0.re = '0;
        c0.im = 16'sd8000;
        c1.re = 16'sd8000;
        c1.im = '0;
        run_estimate(c0, c1, angle);
        check_angle("cfo_angle_o for quarter turn", angle, PI_HALF);
        // increment is the top DDS_W bits of the expected angle
        model_inc = longint'(PI_HALF) >>> (CFO_W - DDS_W);
        smp_in_q.delete();
        exp_out_q.delete();
        s.re = 16'sd1000;
        s.im = '0;
        for (int k = 0; k < STREAM_LEN; k++) begin
            model_derotate(s, e);
            smp_in_q.push_back(s);
            exp_out_q.push_back(e);
        end
        stream_samples(1);
    endtask

    initial begin
        reset_ni = 1'b0;
        corr_valid_i = 1'b0;
        corr_c0_i = '0;
        corr_c1_i = '0;
        smp_valid_i = 1'b0;
        smp_i = '0;
        void'($urandom(49828));
        repeat (3) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;
        @(posedge clk_i);
        #2;

        test_reset_state();
        test_passthrough();
        test_axis_cases();
        test_random_pairs();
        test_derotation();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: cfo_calc/atan_lut.sv
`timescale 1ns/1ps
`default_nettype none

module atan_lut (
    input  logic                          clk_i,
    input  logic [cfo_pkg::LUT_IN_W-1:0]  idx_i,
    output logic [cfo_pkg::LUT_OUT_W-1:0] val_o
);
    import cfo_pkg::*;

    logic [LUT_OUT_W-1:0] rom [2**LUT_IN_W];

    // index spans ratio 0..1, value spans 0..pi/4
    initial begin
        real idx_max;
        real val_max;
        real val;
        idx_max = real'(2**LUT_IN_W - 1);
        val_max = real'(2**(LUT_OUT_W-1) - 1);
        for (int i = 0; i < 2**LUT_IN_W; i++) begin
            val = $atan(real'(i) / idx_max) * 4.0 / PI_REAL * val_max;
            rom[i] = LUT_OUT_W'($rtoi(val + 0.5));
        end
    end

    // registered read so the table lands in block RAM
    always_ff @(posedge clk_i) begin
        val_o <= rom[idx_i];
    end

endmodule

`default_nettype wire

// File: cfo_calc/cfo_calc.sv
`timescale 1ns/1ps
`default_nettype none

module cfo_calc (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic              prod_valid_i,
    input  sample_pkg::cplx_t prod_i,
    output cfo_pkg::angle_t   angle_o,
    output cfo_pkg::dds_inc_t inc_o,
    output logic              valid_o
);
    import sample_pkg::*;
    import cfo_pkg::*;

    est_state_t state_q;
    cplx_t prod_q;

    logic [IQ_W-1:0] mag_re;
    logic [IQ_W-1:0] mag_im;
    logic swap_q;
    logic zero_q;

    // divider working registers
    logic [IQ_W+LUT_IN_W-1:0] rem_q;
    logic [IQ_W+LUT_IN_W-1:0] dvs_q;
    logic [LUT_IN_W:0] quo_q;
    logic [DIV_CNT_W-1:0] bit_cnt_q;

    logic [LUT_IN_W-1:0] lut_idx;
    logic [LUT_OUT_W-1:0] lut_val;

    angle_t oct_val;
    angle_t quad_val;
    angle_t fold_q;
    angle_t angle_next;
    dds_inc_t inc_next;

    // -32768 wraps to 0x8000, which reads correctly as unsigned
    assign mag_re = prod_q.re[IQ_W-1] ? $unsigned(-prod_q.re) : $unsigned(prod_q.re);
    assign mag_im = prod_q.im[IQ_W-1] ? $unsigned(-prod_q.im) : $unsigned(prod_q.im);

    // a ratio of exactly 1 gives 2^LUT_IN_W, clamp to the last entry
    assign lut_idx = quo_q[LUT_IN_W] ? '1 : quo_q[LUT_IN_W-1:0];

    atan_lut atan_lut_i (
        .clk_i (clk_i),
        .idx_i (lut_idx),
        .val_o (lut_val)
    );

    // The table puts pi/4 at 2^(LUT_OUT_W-1)-1, half the angle scale.
    // In those units PI_QUARTER stands for pi/2 and PI_HALF for pi,
    // so the fold runs in table units and EMIT doubles into angle codes.
    assign oct_val = swap_q ? PI_QUARTER - angle_t'(lut_val) : angle_t'(lut_val);

    always_comb begin
        case ({prod_q.im[IQ_W-1], prod_q.re[IQ_W-1]})
            2'b00: quad_val = oct_val;
            2'b01: quad_val = PI_HALF - oct_val;
            2'b11: quad_val = oct_val - PI_HALF;
            default: quad_val = -oct_val;
        endcase
    end

    assign angle_next = fold_q <<< 1;

    generate
        if (DDS_W <= CFO_W) begin : g_inc_msb
            assign inc_next = angle_next[CFO_W-1 -: DDS_W];
        end else begin : g_inc_sext
            assign inc_next = {{(DDS_W-CFO_W){angle_next[CFO_W-1]}}, angle_next};
        end
    endgenerate

    // payload, loaded along the state walk
    always_ff @(posedge clk_i) begin
        case (state_q)
            WAIT_PROD: begin
                if (prod_valid_i) begin
                    prod_q <= prod_i;
                end
            end
            LOAD_DIV: begin
                // smaller magnitude over the larger one keeps the ratio in 0..1
                if (mag_re > mag_im) begin
                    rem_q <= {mag_im, {LUT_IN_W{1'b0}}};
                    dvs_q <= {mag_re, {LUT_IN_W{1'b0}}};
                    swap_q <= 1'b0;
                end else begin
                    rem_q <= {mag_re, {LUT_IN_W{1'b0}}};
                    dvs_q <= {mag_im, {LUT_IN_W{1'b0}}};
                    swap_q <= 1'b1;
                end
                zero_q <= (mag_re == '0) && (mag_im == '0);
                quo_q <= '0;
            end
            DIVIDE: begin
                // restoring step, one quotient bit per cycle from the top
                if (rem_q >= dvs_q) begin
                    rem_q <= rem_q - dvs_q;
                end
                quo_q <= {quo_q[LUT_IN_W-1:0], rem_q >= dvs_q};
                dvs_q <= dvs_q >> 1;
            end
            FOLD: begin
                fold_q <= zero_q ? '0 : quad_val;
            end
            default: begin
            end
        endcase
    end

    // control and outputs
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= WAIT_PROD;
            bit_cnt_q <= '0;
            angle_o <= '0;
            inc_o <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state_q)
                WAIT_PROD: begin
                    // products arriving in any other state are dropped
                    if (prod_valid_i) begin
                        state_q <= LOAD_DIV;
                    end
                end
                LOAD_DIV: begin
                    bit_cnt_q <= DIV_CNT_W'(LUT_IN_W);
                    state_q <= DIVIDE;
                end
                DIVIDE: begin
                    bit_cnt_q <= bit_cnt_q - 1'b1;
                    if (bit_cnt_q == '0) begin
                        state_q <= LOOKUP;
                    end
                end
                // table read is in flight
                LOOKUP: state_q <= FOLD;
                FOLD: state_q <= EMIT;
                EMIT: begin
                    angle_o <= angle_next;
                    inc_o <= inc_next;
                    valid_o <= 1'b1;
                    state_q <= WAIT_PROD;
                end
                default: state_q <= WAIT_PROD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: common/cfo_pkg.sv
`default_nettype none

package cfo_pkg;

    // angle codes, full scale is +-pi
    localparam int CFO_W = 20;

    typedef logic signed [CFO_W-1:0] angle_t;

    // phase increment for the NCO
    localparam int DDS_W = 20;

    typedef logic signed [DDS_W-1:0] dds_inc_t;

    // quotient and arctangent table index
    localparam int LUT_IN_W = 16;

    // table only covers 0..pi/4, so three fewer bits than the angle
    localparam int LUT_OUT_W = CFO_W - 3;

    // bit counter for the restoring divider, counts LUT_IN_W down to 0
    localparam int DIV_CNT_W = $clog2(LUT_IN_W + 1);

    localparam angle_t PI_HALF = angle_t'(2**(CFO_W-2) - 1);
    localparam angle_t PI_QUARTER = angle_t'(2**(CFO_W-3) - 1);

    localparam real PI_REAL = 3.14159265358979;

    typedef enum logic [2:0] {
        WAIT_PROD,
        LOAD_DIV,
        DIVIDE,
        LOOKUP,
        FOLD,
        EMIT
    } est_state_t;

    // phase bits that address the NCO sine table
    localparam int SIN_LUT_AW = 10;

endpackage

`default_nettype wire

// File: common/sample_pkg.sv
`default_nettype none

package sample_pkg;

    // one I or Q component of the sample and correlation streams
    localparam int IQ_W = 16;

    typedef logic signed [IQ_W-1:0] iq_t;

    // complex value, im in the upper half
    typedef struct packed {
        iq_t im;
        iq_t re;
    } cplx_t;

    // a full 16x16 product pair sums to 33 bits
    // dropping 17 keeps the result inside iq_t
    localparam int PROD_SHIFT = 17;

endpackage

`default_nettype wire

// File: hdl/cfo_correct_top.sv
`timescale 1ns/1ps
`default_nettype none

module cfo_correct_top (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic              corr_valid_i,
    input  sample_pkg::cplx_t corr_c0_i,
    input  sample_pkg::cplx_t corr_c1_i,
    input  logic              smp_valid_i,
    input  sample_pkg::cplx_t smp_i,
    output cfo_pkg::angle_t   cfo_angle_o,
    output cfo_pkg::dds_inc_t cfo_inc_o,
    output logic              cfo_valid_o,
    output logic              out_valid_o,
    output sample_pkg::cplx_t out_o
);
    import sample_pkg::*;

    logic prod_valid;
    cplx_t prod;

    // c0 * conj(c1)
    complex_conj_mult complex_conj_mult_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .valid_i  (corr_valid_i),
        .a_i      (corr_c0_i),
        .b_i      (corr_c1_i),
        .valid_o  (prod_valid),
        .prod_o   (prod)
    );

    cfo_calc cfo_calc_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .prod_valid_i (prod_valid),
        .prod_i       (prod),
        .angle_o      (cfo_angle_o),
        .inc_o        (cfo_inc_o),
        .valid_o      (cfo_valid_o)
    );

    // every fresh estimate reloads the NCO increment
    nco_derotator nco_derotator_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .inc_valid_i (cfo_valid_o),
        .inc_i       (cfo_inc_o),
        .smp_valid_i (smp_valid_i),
        .smp_i       (smp_i),
        .out_valid_o (out_valid_o),
        .out_o       (out_o)
    );

endmodule

`default_nettype wire

// File: hdl/complex_conj_mult.sv
`timescale 1ns/1ps
`default_nettype none

module complex_conj_mult (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic              valid_i,
    input  sample_pkg::cplx_t a_i,
    input  sample_pkg::cplx_t b_i,
    output logic              valid_o,
    output sample_pkg::cplx_t prod_o
);
    import sample_pkg::*;

    // partial products of a and b
    logic signed [2*IQ_W-1:0] p_rr;
    logic signed [2*IQ_W-1:0] p_ii;
    logic signed [2*IQ_W-1:0] p_ir;
    logic signed [2*IQ_W-1:0] p_ri;

    logic signed [2*IQ_W:0] sum_re;
    logic signed [2*IQ_W:0] sum_im;

    logic valid_q;

    // conj(b) flips the sign of bi, hence the plus on re and minus on im
    assign sum_re = p_rr + p_ii;
    assign sum_im = p_ir - p_ri;

    always_ff @(posedge clk_i) begin
        p_rr <= a_i.re * b_i.re;
        p_ii <= a_i.im * b_i.im;
        p_ir <= a_i.im * b_i.re;
        p_ri <= a_i.re * b_i.im;

        // arithmetic shift, then keep the low IQ_W bits
        prod_o.re <= iq_t'(sum_re >>> PROD_SHIFT);
        prod_o.im <= iq_t'(sum_im >>> PROD_SHIFT);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= valid_i;
            valid_o <= valid_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/nco_derotator.sv
`timescale 1ns/1ps
`default_nettype none

module nco_derotator (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic              inc_valid_i,
    input  cfo_pkg::dds_inc_t inc_i,
    input  logic              smp_valid_i,
    input  sample_pkg::cplx_t smp_i,
    output logic              out_valid_o,
    output sample_pkg::cplx_t out_o
);
    import sample_pkg::*;
    import cfo_pkg::*;

    // full period, no quarter-wave symmetry
    iq_t sin_lut [2**SIN_LUT_AW];

    dds_inc_t inc_q;
    logic [DDS_W-1:0] phase_q;
    logic [SIN_LUT_AW-1:0] sin_addr;
    logic [SIN_LUT_AW-1:0] cos_addr;

    iq_t sin_q;
    iq_t cos_q;
    cplx_t smp_q;
    logic valid_q;

    logic signed [2*IQ_W:0] rot_re;
    logic signed [2*IQ_W:0] rot_im;

    initial begin
        real amp;
        real val;
        amp = real'(2**(IQ_W-1) - 1);
        for (int i = 0; i < 2**SIN_LUT_AW; i++) begin
            val = amp * $sin(2.0 * PI_REAL * real'(i) / real'(2**SIN_LUT_AW));
            sin_lut[i] = iq_t'((val >= 0.0) ? $rtoi(val + 0.5) : $rtoi(val - 0.5));
        end
    end

    assign sin_addr = phase_q[DDS_W-1 -: SIN_LUT_AW];
    // cosine is the same table a quarter turn ahead
    assign cos_addr = sin_addr + SIN_LUT_AW'(2**(SIN_LUT_AW-2));

    // smp * (cos - j sin)
    assign rot_re = smp_q.re * cos_q + smp_q.im * sin_q;
    assign rot_im = smp_q.im * cos_q - smp_q.re * sin_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            inc_q <= '0;
            phase_q <= '0;
            valid_q <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            // a new increment takes effect from the next sample
            if (inc_valid_i) begin
                inc_q <= inc_i;
            end
            // advance after the current sample has used the old phase
            if (smp_valid_i) begin
                phase_q <= phase_q + $unsigned(inc_q);
            end
            valid_q <= smp_valid_i;
            out_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        sin_q <= sin_lut[sin_addr];
        cos_q <= sin_lut[cos_addr];
        smp_q <= smp_i;

        // table amplitude is 2^(IQ_W-1)-1, scale back and truncate
        out_o.re <= iq_t'(rot_re >>> (IQ_W-1));
        out_o.im <= iq_t'(rot_im >>> (IQ_W-1));
    end

endmodule

`default_nettype wire

// File: project.f
common/sample_pkg.sv
common/cfo_pkg.sv
hdl/complex_conj_mult.sv
cfo_calc/atan_lut.sv
cfo_calc/cfo_calc.sv
hdl/nco_derotator.sv
hdl/cfo_correct_top.sv
bench/tb_cfo_correct.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_cfo_correct \
        -f project.f --Mdir obj_dir -o tb_cfo_correct; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_cfo_correct > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "^Simulation PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
